/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* accel_sequencer.sv */
`timescale 1ns/1ps

module accel_sequencer (
    input  logic               clk,
    input  logic               reset,
    // accelerator command port
    input  logic               acc_req,
    input  mem_pkg::accel_op_t acc_op,
    input  mem_pkg::word_t     acc_mem_addr,
    input  mem_pkg::word_t     acc_buf_addr,
    output logic               acc_done,
    // line port to the cache
    output logic               line_read,
    output logic               line_write,
    output mem_pkg::word_t     line_addr,
    output mem_pkg::line_t     line_wdata,
    input  mem_pkg::line_t     line_rdata,
    input  logic               line_done,
    // bus client
    output logic               acc_bus_read,
    output logic               acc_bus_write,
    output mem_pkg::word_t     acc_bus_addr,
    output mem_pkg::line_t     acc_bus_wdata,
    input  mem_pkg::line_t     bus_rdata,
    input  logic               acc_bus_done
);
    import mem_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_line_rd,
        s_line_wr,
        s_bus_rd,
        s_bus_wr
    } state_t;

    state_t state_q;
    line_t  line_buf_q;
    logic   start;

    // a held command is not restarted during its done cycle
    assign start = (state_q == s_idle) && acc_req && !acc_done;

    assign line_read = (state_q == s_line_rd);
    assign line_write = (state_q == s_line_wr);
    assign line_addr = acc_mem_addr;
    assign line_wdata = line_buf_q;

    assign acc_bus_read = (state_q == s_bus_rd);
    assign acc_bus_write = (state_q == s_bus_wr);
    assign acc_bus_addr = (acc_op == acc_matmul) ? accel_base_addr + output_buffer_offset
                                                 : accel_base_addr + acc_buf_addr;
    assign acc_bus_wdata = line_buf_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= s_idle;
            acc_done <= 1'b0;
        end else begin
            acc_done <= 1'b0;
            case (state_q)
                s_idle: begin
                    if (start) begin
                        case (acc_op)
                            acc_load:   state_q <= s_line_rd;
                            acc_save:   state_q <= s_bus_rd;
                            acc_matmul: state_q <= s_bus_wr;
                            // unknown command finishes without a transfer
                            default:    acc_done <= 1'b1;
                        endcase
                    end
                end
                s_line_rd: begin
                    if (line_done) begin
                        state_q <= s_bus_wr;
                    end
                end
                s_bus_wr: begin
                    if (acc_bus_done) begin
                        state_q <= s_idle;
                        acc_done <= 1'b1;
                    end
                end
                s_bus_rd: begin
                    if (acc_bus_done) begin
                        state_q <= s_line_wr;
                    end
                end
                s_line_wr: begin
                    if (line_done) begin
                        state_q <= s_idle;
                        acc_done <= 1'b1;
                    end
                end
                default: state_q <= s_idle;
            endcase
        end
    end

    // matmul sends an all-zero line
    always_ff @(posedge clk) begin
        if (start && (acc_op == acc_matmul)) begin
            line_buf_q <= '0;
        end else if ((state_q == s_line_rd) && line_done) begin
            line_buf_q <= line_rdata;
        end else if ((state_q == s_bus_rd) && acc_bus_done) begin
            line_buf_q <= bus_rdata;
        end
    end

endmodule

/* bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic           clk,
    input  logic           reset,
    // cache client
    input  logic           cache_read,
    input  logic           cache_write,
    input  mem_pkg::word_t cache_addr,
    input  mem_pkg::line_t cache_wdata,
    output logic           cache_done,
    // sequencer client
    input  logic           acc_read,
    input  logic           acc_write,
    input  mem_pkg::word_t acc_addr,
    input  mem_pkg::line_t acc_wdata,
    output logic           acc_done,
    // main bus
    output logic           bus_read,
    output logic           bus_write,
    output mem_pkg::word_t bus_addr,
    output mem_pkg::line_t bus_wdata,
    input  logic           bus_done
);
    logic busy_q;
    logic sel_acc_q;
    logic sel_acc;

    // an idle bus grants at once with the cache first
    assign sel_acc = busy_q ? sel_acc_q : !(cache_read || cache_write);

    assign bus_read = sel_acc ? acc_read : cache_read;
    assign bus_write = sel_acc ? acc_write : cache_write;
    assign bus_addr = sel_acc ? acc_addr : cache_addr;
    assign bus_wdata = sel_acc ? acc_wdata : cache_wdata;

    assign cache_done = bus_done && !sel_acc;
    assign acc_done = bus_done && sel_acc;

    // owner stays locked from grant until bus_done
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            sel_acc_q <= 1'b0;
        end else if (bus_done) begin
            busy_q <= 1'b0;
        end else if (!busy_q && (bus_read || bus_write)) begin
            busy_q <= 1'b1;
            sel_acc_q <= sel_acc;
        end
    end

endmodule

/* data_cache.sv */
`timescale 1ns/1ps

module data_cache (
    input  logic           clk,
    input  logic           reset,
    // core word port
    input  logic           req_read,
    input  logic           req_write,
    input  mem_pkg::word_t req_addr,
    input  mem_pkg::word_t req_wdata,
    output mem_pkg::word_t req_rdata,
    output logic           req_done,
    // line port from the accelerator sequencer
    input  logic           line_read,
    input  logic           line_write,
    input  mem_pkg::word_t line_addr,
    input  mem_pkg::line_t line_wdata,
    output mem_pkg::line_t line_rdata,
    output logic           line_done,
    // bus client
    output logic           mem_read,
    output logic           mem_write,
    output mem_pkg::word_t mem_addr,
    output mem_pkg::line_t mem_wdata,
    input  mem_pkg::line_t mem_rdata,
    input  logic           mem_done
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_wb,
        s_fill
    } state_t;

    state_t state_q;

    line_t             data_q [num_sets];
    logic [tag_w-1:0]  tag_q [num_sets];
    logic [num_sets-1:0] valid_q;
    logic [num_sets-1:0] dirty_q;

    logic                     use_line;
    logic                     access;
    word_t                    addr;
    logic [tag_w-1:0]         tag;
    logic [set_addr_len-1:0]  set;
    logic [line_addr_len-1:0] word_off;
    logic                     hit;
    logic                     victim_dirty;
    logic                     do_hit;
    logic                     fill_done;

    // the line port wins; the core never overlaps an accelerator command
    assign use_line = line_read | line_write;
    assign addr = use_line ? line_addr : req_addr;

    // ignore the request still held during its own done cycle
    assign access = (use_line | req_read | req_write) & ~(req_done | line_done);

    assign tag = addr[tag_lsb +: tag_w];
    assign set = addr[set_lsb +: set_addr_len];
    assign word_off = addr[byte_off_w +: line_addr_len];

    assign hit = valid_q[set] && (tag_q[set] == tag);
    assign victim_dirty = valid_q[set] && dirty_q[set] && !hit;

    // a line write needs no fill once the victim is clean
    assign do_hit = (state_q == s_idle) && access && (hit || (line_write && !victim_dirty));
    assign fill_done = (state_q == s_fill) && mem_done;

    assign mem_write = (state_q == s_wb);
    assign mem_read = (state_q == s_fill);
    assign mem_addr = mem_write ? {tag_q[set], set, {set_lsb{1'b0}}}
                                : {tag, set, {set_lsb{1'b0}}};
    assign mem_wdata = data_q[set];

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= s_idle;
            valid_q <= '0;
            dirty_q <= '0;
            req_done <= 1'b0;
            line_done <= 1'b0;
        end else begin
            req_done <= do_hit && !use_line;
            line_done <= do_hit && use_line;
            case (state_q)
                s_idle: begin
                    if (do_hit && (req_write || line_write)) begin
                        valid_q[set] <= 1'b1;
                        dirty_q[set] <= 1'b1;
                    end else if (access && !do_hit) begin
                        state_q <= victim_dirty ? s_wb : s_fill;
                    end
                end
                s_wb: begin
                    if (mem_done) begin
                        dirty_q[set] <= 1'b0;
                        // back to idle, where the line write now lands directly
                        state_q <= line_write ? s_idle : s_fill;
                    end
                end
                s_fill: begin
                    if (mem_done) begin
                        valid_q[set] <= 1'b1;
                        dirty_q[set] <= 1'b0;
                        state_q <= s_idle;
                    end
                end
                default: state_q <= s_idle;
            endcase
        end
    end

    // line storage and read data
    always_ff @(posedge clk) begin
        if (do_hit && line_write) begin
            data_q[set] <= line_wdata;
            tag_q[set] <= tag;
        end else if (do_hit && req_write) begin
            data_q[set][word_off*word_w +: word_w] <= req_wdata;
        end else if (fill_done) begin
            data_q[set] <= mem_rdata;
            tag_q[set] <= tag;
        end
        if (do_hit) begin
            req_rdata <= data_q[set][word_off*word_w +: word_w];
            line_rdata <= data_q[set];
        end
    end

endmodule

/* mem_pkg.sv */
package mem_pkg;

    // data word and address width
    localparam int word_w = 32;

    // log2 of words per line
    localparam int line_addr_len = 3;
    localparam int words_per_line = 1 << line_addr_len;
    localparam int line_w = word_w * words_per_line;

    // direct-mapped with 8 sets
    localparam int set_addr_len = 3;
    localparam int num_sets = 1 << set_addr_len;

    // byte offset inside a word
    localparam int byte_off_w = 2;

    // address field positions
    localparam int set_lsb = byte_off_w + line_addr_len;
    localparam int tag_lsb = set_lsb + set_addr_len;
    localparam int tag_w = word_w - set_addr_len - line_addr_len - byte_off_w;

    // accelerator address space on the main bus
    localparam logic [word_w-1:0] accel_base_addr = 32'h8000_0000;
    localparam logic [word_w-1:0] output_buffer_offset = 32'h0000_1000;

    typedef logic [word_w-1:0] word_t;
    typedef logic [line_w-1:0] line_t;

    typedef enum logic [1:0] {
        acc_load,
        acc_save,
        acc_matmul
    } accel_op_t;

endpackage

/* mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
    input  logic               clk,
    input  logic               reset,
    // core port
    input  logic               req_read,
    input  logic               req_write,
    input  mem_pkg::word_t     req_addr,
    input  mem_pkg::word_t     req_wdata,
    output mem_pkg::word_t     req_rdata,
    output logic               req_done,
    // accelerator port
    input  logic               acc_req,
    input  mem_pkg::accel_op_t acc_op,
    input  mem_pkg::word_t     acc_mem_addr,
    input  mem_pkg::word_t     acc_buf_addr,
    output logic               acc_done,
    // main bus
    output logic               bus_read,
    output logic               bus_write,
    output mem_pkg::word_t     bus_addr,
    output mem_pkg::line_t     bus_wdata,
    input  mem_pkg::line_t     bus_rdata,
    input  logic               bus_done
);
    import mem_pkg::*;

    // sequencer to cache line port
    logic  line_read;
    logic  line_write;
    word_t line_addr;
    line_t line_wdata;
    line_t line_rdata;
    logic  line_done;

    // cache bus client
    logic  cache_mem_read;
    logic  cache_mem_write;
    word_t cache_mem_addr;
    line_t cache_mem_wdata;
    logic  cache_mem_done;

    // sequencer bus client
    logic  acc_bus_read;
    logic  acc_bus_write;
    word_t acc_bus_addr;
    line_t acc_bus_wdata;
    logic  acc_bus_done;

    data_cache u_data_cache (
        .clk        (clk),
        .reset      (reset),
        .req_read   (req_read),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_rdata  (req_rdata),
        .req_done   (req_done),
        .line_read  (line_read),
        .line_write (line_write),
        .line_addr  (line_addr),
        .line_wdata (line_wdata),
        .line_rdata (line_rdata),
        .line_done  (line_done),
        .mem_read   (cache_mem_read),
        .mem_write  (cache_mem_write),
        .mem_addr   (cache_mem_addr),
        .mem_wdata  (cache_mem_wdata),
        .mem_rdata  (bus_rdata),
        .mem_done   (cache_mem_done)
    );

    accel_sequencer u_accel_sequencer (
        .clk           (clk),
        .reset         (reset),
        .acc_req       (acc_req),
        .acc_op        (acc_op),
        .acc_mem_addr  (acc_mem_addr),
        .acc_buf_addr  (acc_buf_addr),
        .acc_done      (acc_done),
        .line_read     (line_read),
        .line_write    (line_write),
        .line_addr     (line_addr),
        .line_wdata    (line_wdata),
        .line_rdata    (line_rdata),
        .line_done     (line_done),
        .acc_bus_read  (acc_bus_read),
        .acc_bus_write (acc_bus_write),
        .acc_bus_addr  (acc_bus_addr),
        .acc_bus_wdata (acc_bus_wdata),
        .bus_rdata     (bus_rdata),
        .acc_bus_done  (acc_bus_done)
    );

    // bus_rdata goes straight to both clients
    bus_arbiter u_bus_arbiter (
        .clk         (clk),
        .reset       (reset),
        .cache_read  (cache_mem_read),
        .cache_write (cache_mem_write),
        .cache_addr  (cache_mem_addr),
        .cache_wdata (cache_mem_wdata),
        .cache_done  (cache_mem_done),
        .acc_read    (acc_bus_read),
        .acc_write   (acc_bus_write),
        .acc_addr    (acc_bus_addr),
        .acc_wdata   (acc_bus_wdata),
        .acc_done    (acc_bus_done),
        .bus_read    (bus_read),
        .bus_write   (bus_write),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_done    (bus_done)
    );

endmodule

/* sim.f */
mem_pkg.sv
data_cache.sv
accel_sequencer.sv
bus_arbiter.sv
mem_subsystem.sv
tb_clock.sv
tb_bus_memory.sv
tb_mem_subsystem.sv

/* tb_bus_memory.sv */
`timescale 1ns/1ps

module tb_bus_memory (
    input  logic           clk,
    input  logic           reset,
    input  logic           bus_read,
    input  logic           bus_write,
    input  mem_pkg::word_t bus_addr,
    input  mem_pkg::line_t bus_wdata,
    output mem_pkg::line_t bus_rdata,
    output logic           bus_done,
    // one entry for each finished bus write
    output logic           log_valid,
    output mem_pkg::word_t log_addr,
    output mem_pkg::line_t log_data
);
    import mem_pkg::*;

    // 2 KB of main memory, 8 buffer lines and the output buffer
    line_t main_mem [64];
    line_t acc_buf [8];
    line_t out_buf;

    logic [31:0] lfsr_q;
    logic        busy_q;
    logic [2:0]  wait_q;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic line_t fill_line(input word_t base);
        line_t  l;
        word_t  a;
        for (int w = 0; w < words_per_line; w++) begin
            a = base + word_t'(4 * w);
            l[w*word_w +: word_w] = a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
        end
        return l;
    endfunction

    function automatic line_t read_line(input word_t a);
        if (!a[31]) begin
            return main_mem[a[10:5]];
        end else if (a[15:0] == output_buffer_offset[15:0]) begin
            return out_buf;
        end
        return acc_buf[a[7:5]];
    endfunction

    task automatic write_line(input word_t a, input line_t d);
        if (!a[31]) begin
            main_mem[a[10:5]] = d;
        end else if (a[15:0] == output_buffer_offset[15:0]) begin
            out_buf = d;
        end else begin
            acc_buf[a[7:5]] = d;
        end
    endtask

    initial begin
        lfsr_q = 32'h996c_c923;
        bus_done = 1'b0;
        bus_rdata = '0;
        for (int i = 0; i < 64; i++) begin
            main_mem[i] = fill_line(word_t'(i) << 5);
        end
        for (int i = 0; i < 8; i++) begin
            acc_buf[i] = fill_line(accel_base_addr + (word_t'(i) << 5));
        end
        out_buf = fill_line(accel_base_addr + output_buffer_offset);
    end

    always @(posedge clk) begin
        logic [2:0] delay;
        if (reset) begin
            busy_q <= 1'b0;
            wait_q <= 3'd0;
            bus_done <= 1'b0;
            log_valid <= 1'b0;
        end else begin
            bus_done <= 1'b0;
            log_valid <= 1'b0;
            if (bus_done) begin
                // the finished request is still on the bus in its done cycle
                busy_q <= 1'b0;
            end else if (busy_q && wait_q == 3'd0) begin
                bus_done <= 1'b1;
                if (bus_write) begin
                    write_line(bus_addr, bus_wdata);
                    log_valid <= 1'b1;
                    log_addr <= bus_addr;
                    log_data <= bus_wdata;
                end else begin
                    bus_rdata <= read_line(bus_addr);
                end
            end else if (busy_q) begin
                wait_q <= wait_q - 3'd1;
            end else if (bus_read || bus_write) begin
                // done after 1 to 8 cycles
                delay = 3'd0;
                for (int i = 0; i < 3; i++) begin
                    lfsr_q = lfsr_next(lfsr_q);
                    delay = {delay[1:0], lfsr_q[0]};
                end
                busy_q <= 1'b1;
                wait_q <= delay;
            end
        end
    end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

/* tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int timeout_cycles = 200;
    localparam int num_ops = 600;

    logic      clk;
    logic      reset;
    logic      req_read;
    logic      req_write;
    word_t     req_addr;
    word_t     req_wdata;
    word_t     req_rdata;
    logic      req_done;
    logic      acc_req;
    accel_op_t acc_op;
    word_t     acc_mem_addr;
    word_t     acc_buf_addr;
    logic      acc_done;
    logic      bus_read;
    logic      bus_write;
    word_t     bus_addr;
    line_t     bus_wdata;
    line_t     bus_rdata;
    logic      bus_done;
    logic      log_valid;
    word_t     log_addr;
    line_t     log_data;

    // reference model of main memory and the accelerator buffer
    line_t       model_mem [64];
    line_t       model_buf [8];
    logic [31:0] lfsr_state;

    // what the running accelerator command may write on the bus
    logic  acc_write_allowed;
    logic  in_matmul;
    word_t exp_acc_addr;
    line_t exp_acc_line;
    int    acc_write_count;

    // bus request still waiting for bus_done at the last falling edge
    logic  bus_open;
    logic  open_read;
    logic  open_write;
    word_t open_addr;
    line_t open_wdata;

    tb_clock u_clock (.clk(clk));

    mem_subsystem UUT (.*);

    tb_bus_memory u_mem (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic word_t line_word(input line_t l, input word_t a);
        return l[a[4:2]*word_w +: word_w];
    endfunction

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input line_t got, input line_t exp);
        $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        stop_on_error();
    endtask

    task automatic check_idle_outputs();
        assert (!req_done && !acc_done && !bus_read && !bus_write) else begin
            $display("done or bus request active with no request made at %0t", $time);
            stop_on_error();
        end
    endtask

    task automatic check_bus_write();
        if (!log_addr[31]) begin
            assert (!in_matmul) else begin
                $display("main memory written during MATMUL at %0t", $time);
                stop_on_error();
            end
            assert (log_addr[31:11] == '0 && log_addr[4:0] == '0) else begin
                $display("bus write to a bad main memory address %h at %0t", log_addr, $time);
                stop_on_error();
            end
            assert (log_data == model_mem[log_addr[10:5]]) else
                report_mismatch("bus_wdata", log_data, model_mem[log_addr[10:5]]);
        end else begin
            acc_write_count++;
            assert (acc_write_allowed) else begin
                $display("unexpected write to accelerator space at %0t", $time);
                stop_on_error();
            end
            assert (log_addr == exp_acc_addr) else
                report_mismatch("bus_addr", line_t'(log_addr), line_t'(exp_acc_addr));
            assert (log_data == exp_acc_line) else
                report_mismatch("bus_wdata", log_data, exp_acc_line);
        end
    endtask

    always @(negedge clk) begin
        if (bus_open) begin
            assert (bus_read === open_read && bus_write === open_write &&
                    bus_addr === open_addr && bus_wdata === open_wdata) else begin
                $display("bus request changed before bus_done at %0t", $time);
                stop_on_error();
            end
        end
        bus_open = (bus_read || bus_write) && !bus_done;
        open_read = bus_read;
        open_write = bus_write;
        open_addr = bus_addr;
        open_wdata = bus_wdata;
        if (log_valid) begin
            check_bus_write();
        end
    end

    task automatic wait_req_done();
        for (int n = 0; n < timeout_cycles; n++) begin
            @(negedge clk);
            if (req_done) break;
        end
        assert (req_done) else begin
            $display("timeout waiting for req_done at %0t", $time);
            stop_on_error();
        end
    endtask

    task automatic wait_acc_done();
        for (int n = 0; n < timeout_cycles; n++) begin
            @(negedge clk);
            if (acc_done) break;
        end
        assert (acc_done) else begin
            $display("timeout waiting for acc_done at %0t", $time);
            stop_on_error();
        end
    endtask

    task automatic core_store(input word_t a, input word_t d);
        @(posedge clk);
        req_write <= 1'b1;
        req_addr <= a;
        req_wdata <= d;
        wait_req_done();
        model_mem[a[10:5]][a[4:2]*word_w +: word_w] = d;
        @(posedge clk);
        req_write <= 1'b0;
        @(negedge clk);
        assert (!req_done) else report_mismatch("req_done", line_t'(req_done), '0);
    endtask

    task automatic core_load(input word_t a);
        word_t exp;
        exp = line_word(model_mem[a[10:5]], a);
        @(posedge clk);
        req_read <= 1'b1;
        req_addr <= a;
        wait_req_done();
        assert (req_rdata == exp) else
            report_mismatch("req_rdata", line_t'(req_rdata), line_t'(exp));
        @(posedge clk);
        req_read <= 1'b0;
        @(negedge clk);
        assert (!req_done) else report_mismatch("req_done", line_t'(req_done), '0);
    endtask

    task automatic accel_command(input accel_op_t op, input word_t mem_a, input word_t buf_off);
        acc_write_count = 0;
        acc_write_allowed = (op != acc_save);
        in_matmul = (op == acc_matmul);
        if (op == acc_matmul) begin
            exp_acc_addr = accel_base_addr + output_buffer_offset;
            exp_acc_line = '0;
        end else begin
            exp_acc_addr = accel_base_addr + buf_off;
            exp_acc_line = model_mem[mem_a[10:5]];
        end
        @(posedge clk);
        acc_req <= 1'b1;
        acc_op <= op;
        acc_mem_addr <= mem_a;
        acc_buf_addr <= buf_off;
        wait_acc_done();
        if (op == acc_save) begin
            model_mem[mem_a[10:5]] = model_buf[buf_off[7:5]];
        end else begin
            assert (acc_write_count == 1) else begin
                $display("%0d accelerator-space writes instead of one at %0t",
                         acc_write_count, $time);
                stop_on_error();
            end
            if (op == acc_load) begin
                model_buf[buf_off[7:5]] = model_mem[mem_a[10:5]];
            end
        end
        @(posedge clk);
        acc_req <= 1'b0;
        acc_write_allowed = 1'b0;
        in_matmul = 1'b0;
        @(negedge clk);
        assert (!acc_done) else report_mismatch("acc_done", line_t'(acc_done), '0);
    endtask

    initial begin
        logic [31:0] pick;
        logic [31:0] widx;
        logic [31:0] data;
        logic [31:0] boff;
        word_t       addr;
        word_t       base;
        lfsr_state = 32'h996c_c923;
        reset = 1'b1;
        req_read = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        acc_req = 1'b0;
        acc_op = acc_load;
        acc_mem_addr = '0;
        acc_buf_addr = '0;
        acc_write_allowed = 1'b0;
        in_matmul = 1'b0;
        acc_write_count = 0;
        bus_open = 1'b0;

        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_idle_outputs();
        end

        // start from the memory contents before any traffic
        for (int i = 0; i < 64; i++) begin
            model_mem[i] = u_mem.main_mem[i];
        end
        for (int i = 0; i < 8; i++) begin
            model_buf[i] = u_mem.acc_buf[i];
        end

        for (int k = 0; k < num_ops; k++) begin
            take_bits(3, pick);
            take_bits(9, widx);
            addr = {21'b0, widx[8:0], 2'b00};
            base = {addr[31:5], 5'b0};
            case (pick[2:0])
                3'd0, 3'd1, 3'd2: begin
                    take_bits(32, data);
                    core_store(addr, data);
                end
                3'd3, 3'd4: core_load(addr);
                3'd5: begin
                    take_bits(3, boff);
                    accel_command(acc_load, base, {24'b0, boff[2:0], 5'b0});
                end
                3'd6: begin
                    take_bits(3, boff);
                    accel_command(acc_save, base, {24'b0, boff[2:0], 5'b0});
                    core_load(addr);
                end
                default: accel_command(acc_matmul, base, '0);
            endcase
        end

        repeat (4) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule
